//--- dual_issue.f
hdl/issue_pkg.sv
hdl/fetch_bridge.sv
hdl/rv_decode.sv
hdl/issue_queue.sv
hdl/dual_issue.sv
tests/clock_gen.sv
tests/issue_checker.sv
tests/tb_dual_issue.sv

//--- Bender.yml
package:
  name: dual_issue

sources:
  - hdl/issue_pkg.sv
  - hdl/fetch_bridge.sv
  - hdl/rv_decode.sv
  - hdl/issue_queue.sv
  - hdl/dual_issue.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/issue_checker.sv
      - tests/tb_dual_issue.sv

//--- tests/tb_dual_issue.sv
`default_nettype none

module tb_dual_issue;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_rows = 14;
  localparam int random_pairs = 40;
  localparam int cycle_limit = num_rows * 12 + random_pairs * 12 + 100;

  localparam int m_plain = 0;
  localparam int m_hold = 1;
  localparam int m_probe = 2;
  localparam int m_flush = 3;

  localparam logic [31:0] addi_x1 = 32'h00100093;
  localparam logic [31:0] addi_x2 = 32'h00200113;
  localparam logic [31:0] addi_x5 = 32'h00500293;
  localparam logic [31:0] addi_x0 = 32'h00500013;
  localparam logic [31:0] add_x3 = 32'h002081b3;
  localparam logic [31:0] add_x3_zero = 32'h000001b3;
  localparam logic [31:0] add_x8 = 32'h00128433;
  localparam logic [31:0] lw_x6 = 32'h00052303;
  localparam logic [31:0] lw_x7 = 32'h0045a383;
  localparam logic [31:0] mul_x9 = 32'h020084b3;
  localparam logic [31:0] nop = 32'h00000013;
  localparam logic [65:0] none = '0;

  logic        clock;
  logic        reset;
  logic        fetch_req;
  logic [31:0] fetch_word0;
  logic [31:0] fetch_word1;
  logic        fetch_valid0;
  logic        fetch_valid1;
  logic        fetch_ack;
  logic        issue_hold;
  logic        flush;
  logic [31:0] issue_word0;
  logic        issue_valid0;
  logic [31:0] issue_word1;
  logic        issue_valid1;
  logic        issue_swap;
  logic        queue_stall;

  string       row_name[num_rows];
  logic [31:0] row_w0[num_rows];
  logic [31:0] row_w1[num_rows];
  logic [1:0]  row_valid[num_rows];
  int          row_mode[num_rows];
  int          row_nexp[num_rows];
  logic [65:0] row_exp0[num_rows];
  logic [65:0] row_exp1[num_rows];
  logic [31:0] pool[7];
  logic [31:0] rand_w0[random_pairs];
  logic [31:0] rand_w1[random_pairs];

  integer seed;
  int     protocol_errors;
  int     cycles;
  int     total;
  logic   random_phase;

  clock_gen clocks (.clock(clock), .reset(reset));

  dual_issue #(.queue_depth(8)) dual_issue_inst (
    .clock(clock), .reset(reset), .fetch_req(fetch_req),
    .fetch_word0(fetch_word0), .fetch_word1(fetch_word1),
    .fetch_valid0(fetch_valid0), .fetch_valid1(fetch_valid1), .fetch_ack(fetch_ack),
    .issue_hold(issue_hold), .flush(flush),
    .issue_word0(issue_word0), .issue_valid0(issue_valid0),
    .issue_word1(issue_word1), .issue_valid1(issue_valid1),
    .issue_swap(issue_swap), .queue_stall(queue_stall)
  );

  issue_checker issue_check (
    .clock(clock), .reset(reset),
    .issue_word0(issue_word0), .issue_valid0(issue_valid0),
    .issue_word1(issue_word1), .issue_valid1(issue_valid1), .issue_swap(issue_swap)
  );

  function automatic logic [65:0] rec(input logic [31:0] w0, input logic [31:0] w1,
                                      input logic v1, input logic swap);
    return {w0, w1, v1, swap};
  endfunction

  task automatic set_row(input int i, input string name, input logic [31:0] w0,
                         input logic [31:0] w1, input logic [1:0] valid, input int mode,
                         input int nexp, input logic [65:0] e0, input logic [65:0] e1);
    row_name[i]  = name;
    row_w0[i]    = w0;
    row_w1[i]    = w1;
    row_valid[i] = valid;
    row_mode[i]  = mode;
    row_nexp[i]  = nexp;
    row_exp0[i]  = e0;
    row_exp1[i]  = e1;
  endtask

  // one full four-phase exchange.
  task automatic exchange(input logic [31:0] w0, input logic [31:0] w1,
                          input logic [1:0] valid, input logic to_model, input logic probe);
    @(negedge clock);
    fetch_word0  = w0;
    fetch_word1  = w1;
    fetch_valid0 = valid[0];
    fetch_valid1 = valid[1];
    fetch_req    = 1'b1;
    if (probe) begin
      repeat (6) begin
        @(negedge clock);
        if (fetch_ack) begin
          protocol_errors++;
          $display("fetch_ack rose while the queue was stalled");
        end
      end
      issue_hold = 1'b0;
    end
    @(negedge clock);
    while (!fetch_ack) @(negedge clock);
    // the pair is in the queue during this cycle.
    if (to_model && valid[0] && w0 != nop) issue_check.push_program(w0);
    if (to_model && valid[1] && w1 != nop) issue_check.push_program(w1);
    fetch_req = 1'b0;
    while (fetch_ack) @(negedge clock);
  endtask

  task automatic drain();
    while (issue_check.pending() != 0) @(negedge clock);
  endtask

  always @(negedge clock) begin
    if (random_phase) begin
      issue_hold = ($random(seed) & 3) == 0;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles with work still pending", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    fetch_req = 1'b0;
    fetch_word0 = '0;
    fetch_word1 = '0;
    fetch_valid0 = 1'b0;
    fetch_valid1 = 1'b0;
    issue_hold = 1'b0;
    flush = 1'b0;
    random_phase = 1'b0;
    seed = 32'h8d96f9f5;
    protocol_errors = 0;
    cycles = 0;
    pool = '{addi_x1, addi_x5, add_x8, lw_x6, lw_x7, mul_x9, add_x3};

    // random program drawn up front.
    for (int i = 0; i < random_pairs; i++) begin
      rand_w0[i] = pool[$unsigned($random(seed)) % 7];
      rand_w1[i] = pool[$unsigned($random(seed)) % 7];
    end

    set_row(0, "alu_pair", addi_x1, addi_x2, 2'b11, m_plain, 1,
            rec(addi_x1, addi_x2, 1, 0), none);
    set_row(1, "alu_load_swap", addi_x1, lw_x6, 2'b11, m_plain, 1,
            rec(lw_x6, addi_x1, 1, 1), none);
    set_row(2, "load_load", lw_x6, lw_x7, 2'b11, m_plain, 2,
            rec(lw_x6, 0, 0, 0), rec(lw_x7, 0, 0, 0));
    set_row(3, "raw_x5", addi_x5, add_x8, 2'b11, m_plain, 2,
            rec(addi_x5, 0, 0, 0), rec(add_x8, 0, 0, 0));
    set_row(4, "x0_write", addi_x0, add_x3_zero, 2'b11, m_plain, 1,
            rec(addi_x0, add_x3_zero, 1, 0), none);
    set_row(5, "nop_slot", nop, addi_x1, 2'b11, m_plain, 1, rec(addi_x1, 0, 0, 0), none);
    set_row(6, "invalid_slot", addi_x2, mul_x9, 2'b10, m_plain, 1,
            rec(mul_x9, 0, 0, 0), none);
    set_row(7, "hold_fill_a", addi_x1, addi_x2, 2'b11, m_hold, 1,
            rec(addi_x1, addi_x2, 1, 0), none);
    set_row(8, "hold_fill_b", addi_x5, add_x3, 2'b11, m_hold, 1,
            rec(addi_x5, add_x3, 1, 0), none);
    set_row(9, "hold_fill_c", lw_x6, addi_x1, 2'b11, m_hold, 1,
            rec(lw_x6, addi_x1, 1, 0), none);
    set_row(10, "stall_probe", addi_x2, add_x3, 2'b11, m_probe, 2,
            rec(addi_x2, 0, 0, 0), rec(add_x3, 0, 0, 0));
    set_row(11, "flush_drop", mul_x9, lw_x6, 2'b11, m_flush, 0, none, none);
    set_row(12, "after_flush", addi_x1, mul_x9, 2'b11, m_plain, 2,
            rec(addi_x1, 0, 0, 0), rec(mul_x9, 0, 0, 0));
    set_row(13, "alu_mul_swap", addi_x5, mul_x9, 2'b11, m_plain, 1,
            rec(mul_x9, addi_x5, 1, 1), none);

    @(posedge reset);
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clock);
      if (row_mode[i] != m_probe) begin
        issue_hold = (row_mode[i] == m_hold) || (row_mode[i] == m_flush);
      end else if (!queue_stall) begin
        protocol_errors++;
        $display("%s: queue_stall stayed low with six entries held", row_name[i]);
      end
      if (row_nexp[i] > 0) issue_check.expect_record(row_name[i], row_exp0[i]);
      if (row_nexp[i] > 1) issue_check.expect_record(row_name[i], row_exp1[i]);
      exchange(row_w0[i], row_w1[i], row_valid[i], 1'b0, row_mode[i] == m_probe);
      if (row_mode[i] == m_flush) begin
        @(negedge clock);
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        issue_hold = 1'b0;
      end
      if (row_mode[i] != m_hold) drain();
    end

    @(posedge clock);
    random_phase = 1'b1;
    for (int i = 0; i < random_pairs; i++) begin
      exchange(rand_w0[i], rand_w1[i], 2'b11, 1'b1, 1'b0);
    end
    @(posedge clock);
    random_phase = 1'b0;
    @(negedge clock);
    issue_hold = 1'b0;
    drain();
    repeat (3) @(negedge clock);

    total = issue_check.mismatch_count + issue_check.stray_count + protocol_errors;
    $display("errors: %0d mismatches, %0d unexpected issues, %0d protocol",
             issue_check.mismatch_count, issue_check.stray_count, protocol_errors);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/issue_checker.sv
`default_nettype none

module issue_checker (
  input logic        clock,
  input logic        reset,
  input logic [31:0] issue_word0,
  input logic        issue_valid0,
  input logic [31:0] issue_word1,
  input logic        issue_valid1,
  input logic        issue_swap
);

  timeunit 1ns;
  timeprecision 1ps;

  // record layout is {word0, word1, valid1, swap}.
  logic [65:0] exp_q[$];
  string       name_q[$];
  logic [31:0] prog_q[$];
  int          mismatch_count = 0;
  int          stray_count = 0;

  task automatic expect_record(input string name, input logic [65:0] rec);
    exp_q.push_back(rec);
    name_q.push_back(name);
  endtask

  task automatic push_program(input logic [31:0] word);
    prog_q.push_back(word);
  endtask

  function automatic int pending();
    return exp_q.size() + prog_q.size();
  endfunction

  function automatic logic is_basic(input logic [31:0] w);
    case (w[6:0])
      7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011, 7'b0010011: return 1'b1;
      7'b0110011: return w[31:25] != 7'd1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic writes_rd(input logic [31:0] w);
    case (w[6:0])
      7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b0010011, 7'b0110011,
      7'b0000011: return w[11:7] != 5'd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic reads_rs1(input logic [31:0] w);
    case (w[6:0])
      7'b1100111, 7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011,
      7'b0110011: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic reads_rs2(input logic [31:0] w);
    return (w[6:0] == 7'b1100011) || (w[6:0] == 7'b0100011) || (w[6:0] == 7'b0110011);
  endfunction

  // pairing rules applied to the two oldest words in program order.
  function automatic logic [65:0] model_next();
    logic [31:0] older;
    logic [31:0] younger;
    logic        hazard;
    logic        swap;
    older = prog_q[0];
    if (prog_q.size() < 2) begin
      return {older, 32'd0, 1'b0, 1'b0};
    end
    younger = prog_q[1];
    hazard = writes_rd(older) &&
             ((reads_rs1(younger) && younger[19:15] == older[11:7]) ||
              (reads_rs2(younger) && younger[24:20] == older[11:7]));
    if (hazard || (!is_basic(older) && !is_basic(younger))) begin
      return {older, 32'd0, 1'b0, 1'b0};
    end
    swap = is_basic(older) && !is_basic(younger);
    return swap ? {younger, older, 1'b1, 1'b1} : {older, younger, 1'b1, 1'b0};
  endfunction

  always @(posedge clock) begin : sample
    logic [65:0] exp;
    string       name;
    logic        have;
    logic        bad;
    if (reset && issue_valid0) begin
      have = 1'b1;
      if (exp_q.size() > 0) begin
        exp  = exp_q.pop_front();
        name = name_q.pop_front();
      end else if (prog_q.size() > 0) begin
        exp  = model_next();
        name = "random";
        void'(prog_q.pop_front());
        if (exp[1]) begin
          void'(prog_q.pop_front());
        end
      end else begin
        have = 1'b0;
        stray_count++;
        $display("issued %h while nothing was expected", issue_word0);
      end
      if (have) begin
        bad = (issue_word0 !== exp[65:34]) || (issue_valid1 !== exp[1]) ||
              (issue_swap !== exp[0]) || (exp[1] && issue_word1 !== exp[33:2]);
        if (bad) begin
          mismatch_count++;
          $display("MISMATCH %s expected %h %h v1=%b swap=%b actual %h %h v1=%b swap=%b",
                   name, exp[65:34], exp[33:2], exp[1], exp[0],
                   issue_word0, issue_word1, issue_valid1, issue_swap);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // reset low for the first 4 cycles.
  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

`default_nettype wire

//--- hdl/dual_issue.sv
`default_nettype none

module dual_issue #(
  parameter int queue_depth = 8
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_req,
  input  logic [31:0] fetch_word0,
  input  logic [31:0] fetch_word1,
  input  logic        fetch_valid0,
  input  logic        fetch_valid1,
  output logic        fetch_ack,
  input  logic        issue_hold,
  input  logic        flush,
  output logic [31:0] issue_word0,
  output logic        issue_valid0,
  output logic [31:0] issue_word1,
  output logic        issue_valid1,
  output logic        issue_swap,
  output logic        queue_stall
);

  import issue_pkg::*;

  logic        write_strobe;
  logic [31:0] slot_word0, slot_word1;
  logic        slot_valid0, slot_valid1;

  logic                       lane0_dec_valid, lane0_dec_nop;
  class_e                     lane0_dec_class;
  logic [reg_index_width-1:0] lane0_dec_rd, lane0_dec_rs1, lane0_dec_rs2;
  logic                       lane0_dec_wren, lane0_dec_rden1, lane0_dec_rden2;

  logic                       lane1_dec_valid, lane1_dec_nop;
  class_e                     lane1_dec_class;
  logic [reg_index_width-1:0] lane1_dec_rd, lane1_dec_rs1, lane1_dec_rs2;
  logic                       lane1_dec_wren, lane1_dec_rden1, lane1_dec_rden2;

  fetch_bridge bridge (
    .clock        (clock),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .fetch_word0  (fetch_word0),
    .fetch_word1  (fetch_word1),
    .fetch_valid0 (fetch_valid0),
    .fetch_valid1 (fetch_valid1),
    .queue_stall  (queue_stall),
    .fetch_ack    (fetch_ack),
    .write_strobe (write_strobe),
    .slot_word0   (slot_word0),
    .slot_word1   (slot_word1),
    .slot_valid0  (slot_valid0),
    .slot_valid1  (slot_valid1)
  );

  // one decoder per fetch slot.
  rv_decode lane0_dec (
    .word      (slot_word0),
    .valid     (slot_valid0),
    .dec_valid (lane0_dec_valid),
    .dec_nop   (lane0_dec_nop),
    .dec_class (lane0_dec_class),
    .dec_rd    (lane0_dec_rd),
    .dec_wren  (lane0_dec_wren),
    .dec_rs1   (lane0_dec_rs1),
    .dec_rden1 (lane0_dec_rden1),
    .dec_rs2   (lane0_dec_rs2),
    .dec_rden2 (lane0_dec_rden2)
  );

  rv_decode lane1_dec (
    .word      (slot_word1),
    .valid     (slot_valid1),
    .dec_valid (lane1_dec_valid),
    .dec_nop   (lane1_dec_nop),
    .dec_class (lane1_dec_class),
    .dec_rd    (lane1_dec_rd),
    .dec_wren  (lane1_dec_wren),
    .dec_rs1   (lane1_dec_rs1),
    .dec_rden1 (lane1_dec_rden1),
    .dec_rs2   (lane1_dec_rs2),
    .dec_rden2 (lane1_dec_rden2)
  );

  issue_queue #(
    .queue_depth (queue_depth)
  ) queue (
    .clock           (clock),
    .reset           (reset),
    .flush           (flush),
    .issue_hold      (issue_hold),
    .write_strobe    (write_strobe),
    .lane0_word      (slot_word0),
    .lane1_word      (slot_word1),
    .lane0_dec_valid (lane0_dec_valid),
    .lane0_dec_nop   (lane0_dec_nop),
    .lane0_dec_class (lane0_dec_class),
    .lane0_dec_rd    (lane0_dec_rd),
    .lane0_dec_wren  (lane0_dec_wren),
    .lane0_dec_rs1   (lane0_dec_rs1),
    .lane0_dec_rden1 (lane0_dec_rden1),
    .lane0_dec_rs2   (lane0_dec_rs2),
    .lane0_dec_rden2 (lane0_dec_rden2),
    .lane1_dec_valid (lane1_dec_valid),
    .lane1_dec_nop   (lane1_dec_nop),
    .lane1_dec_class (lane1_dec_class),
    .lane1_dec_rd    (lane1_dec_rd),
    .lane1_dec_wren  (lane1_dec_wren),
    .lane1_dec_rs1   (lane1_dec_rs1),
    .lane1_dec_rden1 (lane1_dec_rden1),
    .lane1_dec_rs2   (lane1_dec_rs2),
    .lane1_dec_rden2 (lane1_dec_rden2),
    .issue_word0     (issue_word0),
    .issue_word1     (issue_word1),
    .issue_valid0    (issue_valid0),
    .issue_valid1    (issue_valid1),
    .issue_swap      (issue_swap),
    .queue_stall     (queue_stall)
  );

endmodule

`default_nettype wire

//--- hdl/issue_queue.sv
`default_nettype none

module issue_queue #(
  parameter int queue_depth = 8
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 flush,
  input  logic                                 issue_hold,
  input  logic                                 write_strobe,
  input  logic [31:0]                          lane0_word,
  input  logic [31:0]                          lane1_word,
  input  logic                                 lane0_dec_valid,
  input  logic                                 lane0_dec_nop,
  input  issue_pkg::class_e                    lane0_dec_class,
  input  logic [issue_pkg::reg_index_width-1:0] lane0_dec_rd,
  input  logic                                 lane0_dec_wren,
  input  logic [issue_pkg::reg_index_width-1:0] lane0_dec_rs1,
  input  logic                                 lane0_dec_rden1,
  input  logic [issue_pkg::reg_index_width-1:0] lane0_dec_rs2,
  input  logic                                 lane0_dec_rden2,
  input  logic                                 lane1_dec_valid,
  input  logic                                 lane1_dec_nop,
  input  issue_pkg::class_e                    lane1_dec_class,
  input  logic [issue_pkg::reg_index_width-1:0] lane1_dec_rd,
  input  logic                                 lane1_dec_wren,
  input  logic [issue_pkg::reg_index_width-1:0] lane1_dec_rs1,
  input  logic                                 lane1_dec_rden1,
  input  logic [issue_pkg::reg_index_width-1:0] lane1_dec_rs2,
  input  logic                                 lane1_dec_rden2,
  output logic [31:0]                          issue_word0,
  output logic [31:0]                          issue_word1,
  output logic                                 issue_valid0,
  output logic                                 issue_valid1,
  output logic                                 issue_swap,
  output logic                                 queue_stall
);

  import issue_pkg::*;

  localparam int ptr_width = $clog2(queue_depth);

  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [ptr_width:0]   count_t;

  typedef struct packed {
    logic [31:0]                word;
    class_e                     cls;
    logic [reg_index_width-1:0] rd;
    logic                       wren;
    logic [reg_index_width-1:0] rs1;
    logic                       rden1;
    logic [reg_index_width-1:0] rs2;
    logic                       rden2;
  } entry_t;

  entry_t mem [queue_depth];
  entry_t mem_next [queue_depth];
  entry_t lane0_entry;
  entry_t lane1_entry;
  entry_t older;
  entry_t younger;

  ptr_t   head, tail, head_v, tail_v;
  count_t count, count_v, count_next;
  logic   accept0, accept1;
  logic   hazard, pair_ok, swap;
  logic [1:0] pass;

  assign lane0_entry = '{lane0_word, lane0_dec_class, lane0_dec_rd, lane0_dec_wren,
                         lane0_dec_rs1, lane0_dec_rden1, lane0_dec_rs2, lane0_dec_rden2};
  assign lane1_entry = '{lane1_word, lane1_dec_class, lane1_dec_rd, lane1_dec_wren,
                         lane1_dec_rs1, lane1_dec_rden1, lane1_dec_rs2, lane1_dec_rden2};

  assign accept0 = write_strobe && lane0_dec_valid && !lane0_dec_nop;
  assign accept1 = write_strobe && lane1_dec_valid && !lane1_dec_nop;

  always_comb begin
    mem_next = mem;
    head_v   = head;
    tail_v   = tail;
    count_v  = count;
    if (flush) begin
      head_v  = '0;
      tail_v  = '0;
      count_v = '0;
    end else begin
      // lane0 is older and goes in first.
      if (accept0) begin
        mem_next[tail_v] = lane0_entry;
        tail_v           = tail_v + ptr_t'(1);
        count_v          = count_v + count_t'(1);
      end
      if (accept1) begin
        mem_next[tail_v] = lane1_entry;
        tail_v           = tail_v + ptr_t'(1);
        count_v          = count_v + count_t'(1);
      end
    end

    // oldest two entries, this cycle's writes included.
    older   = mem_next[head_v];
    younger = mem_next[head_v + ptr_t'(1)];

    hazard = older.wren &&
             ((younger.rden1 && younger.rs1 == older.rd) ||
              (younger.rden2 && younger.rs2 == older.rd));
    pair_ok = ((older.cls == cls_basic) || (younger.cls == cls_basic)) && !hazard;

    // entries beyond the count are never looked at.
    if (issue_hold || (count_v == '0)) begin
      pass = 2'd0;
    end else if ((count_v == count_t'(1)) || !pair_ok) begin
      pass = 2'd1;
    end else begin
      pass = 2'd2;
    end

    swap = (pass == 2'd2) && (older.cls == cls_basic) && (younger.cls == cls_complex);
    count_next = count_v - count_t'(pass);
  end

  // complex instruction always leaves through slot 0.
  assign issue_valid0 = (pass != 2'd0);
  assign issue_valid1 = (pass == 2'd2);
  assign issue_swap   = swap;
  assign issue_word0  = issue_valid0 ? (swap ? younger.word : older.word) : '0;
  assign issue_word1  = issue_valid1 ? (swap ? older.word : younger.word) : '0;

  always_ff @(posedge clock) begin
    if (!reset) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      queue_stall <= 1'b0;
    end else begin
      head        <= head_v + ptr_t'(pass);
      tail        <= tail_v;
      count       <= count_next;
      queue_stall <= (count_next > count_t'(queue_depth / 2));
    end
  end

  always_ff @(posedge clock) begin
    mem <= mem_next;
  end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`default_nettype none

module rv_decode (
  input  logic [31:0]                          word,
  input  logic                                 valid,
  output logic                                 dec_valid,
  output logic                                 dec_nop,
  output issue_pkg::class_e                    dec_class,
  output logic [issue_pkg::reg_index_width-1:0] dec_rd,
  output logic                                 dec_wren,
  output logic [issue_pkg::reg_index_width-1:0] dec_rs1,
  output logic                                 dec_rden1,
  output logic [issue_pkg::reg_index_width-1:0] dec_rs2,
  output logic                                 dec_rden2
);

  import issue_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  class_e     klass;
  logic       writes_rd;
  logic       reads_rs1;
  logic       reads_rs2;

  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];

  assign dec_rd  = word[11:7];
  assign dec_rs1 = word[19:15];
  assign dec_rs2 = word[24:20];

  always_comb begin
    klass     = cls_complex;
    writes_rd = 1'b0;
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    case (opcode)
      op_lui, op_auipc, op_jal: begin
        klass     = cls_basic;
        writes_rd = 1'b1;
      end
      op_jalr, op_imm: begin
        klass     = cls_basic;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      op_branch: begin
        klass     = cls_basic;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      op_reg: begin
        // funct7 of 1 selects the M extension.
        klass     = (funct7 == 7'd1) ? cls_complex : cls_basic;
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      op_load: begin
        writes_rd = 1'b1;
        reads_rs1 = 1'b1;
      end
      op_store: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      op_system: begin
        // csr ops. funct3[2] marks the immediate forms.
        writes_rd = (funct3 != 3'd0);
        reads_rs1 = (funct3 != 3'd0) && !funct3[2];
      end
      default: begin
        klass = cls_complex;
      end
    endcase
  end

  assign dec_valid = valid;
  assign dec_nop   = valid && (word == nop_word);
  assign dec_class = valid ? klass : cls_none;
  assign dec_wren  = valid && writes_rd && (dec_rd != '0);
  assign dec_rden1 = valid && reads_rs1;
  assign dec_rden2 = valid && reads_rs2;

endmodule

`default_nettype wire

//--- hdl/fetch_bridge.sv
`default_nettype none

module fetch_bridge (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_req,
  input  logic [31:0] fetch_word0,
  input  logic [31:0] fetch_word1,
  input  logic        fetch_valid0,
  input  logic        fetch_valid1,
  input  logic        queue_stall,
  output logic        fetch_ack,
  output logic        write_strobe,
  output logic [31:0] slot_word0,
  output logic [31:0] slot_word1,
  output logic        slot_valid0,
  output logic        slot_valid1
);

  typedef enum logic [1:0] {
    st_idle,
    st_captured,
    st_wait_low
  } state_e;

  state_e state;
  logic   take;

  // a pending request waits while the queue is stalled.
  assign take = (state == st_idle) && fetch_req && !queue_stall;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            state <= st_captured;
          end
        end
        st_captured: begin
          state <= fetch_req ? st_wait_low : st_idle;
        end
        st_wait_low: begin
          if (!fetch_req) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      slot_word0  <= fetch_word0;
      slot_word1  <= fetch_word1;
      slot_valid0 <= fetch_valid0;
      slot_valid1 <= fetch_valid1;
    end
  end

  // strobe lasts the single cycle spent in captured.
  assign fetch_ack    = (state != st_idle);
  assign write_strobe = (state == st_captured);

endmodule

`default_nettype wire

//--- hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // register index width of the base integer ISA.
  localparam int reg_index_width = 5;

  // instruction class as seen by the pairing logic.
  typedef enum logic [1:0] {
    cls_none    = 2'd0,
    cls_basic   = 2'd1,
    cls_complex = 2'd2
  } class_e;

  // major opcodes, bits 6:0 of the instruction.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  // addi x0,x0,0.
  localparam logic [31:0] nop_word = 32'h00000013;

endpackage

`default_nettype wire
